// File: hw/include/fractal_sync_defs.svh
// fractal sync constants: array size, node fan-out and barrier level coding.
`ifndef FRACTAL_SYNC_DEFS_SVH
`define FRACTAL_SYNC_DEFS_SVH

`default_nettype none

// array geometry.
`define FSYNC_GRID_DIM 4
`define FSYNC_N_CU     16

// tree shape, every node has the same fan-out.
`define FSYNC_N_CHILD  4
`define FSYNC_N_LEAF   4

// level coding, 1 is a quadrant and 2 the whole array.
`define FSYNC_LVL_W    2
`define FSYNC_TOP_LVL  2

`default_nettype wire

`endif

// File: hw/pkg/fsync_cu_pkg.sv
// fsync cu package: types seen on the compute unit side of the barrier network.
`include "fractal_sync_defs.svh"
`default_nettype none

package fsync_cu_pkg;

  // barrier level requested by a cu and echoed back with the wake.
  // 1 = quadrant, 2 = whole array, 0 and 3 are rejected.
  typedef logic [`FSYNC_LVL_W-1:0] lvl_t;

  // row-major position of a cu in the array.
  typedef logic [$clog2(`FSYNC_N_CU)-1:0] cu_idx_t;

endpackage : fsync_cu_pkg

`default_nettype wire

// File: hw/pkg/fsync_node_pkg.sv
// fsync node package: types for the arrival state kept inside a tree node.
`include "fractal_sync_defs.svh"
`default_nettype none

package fsync_node_pkg;

  // one bit per child link of a node.
  typedef logic [`FSYNC_N_CHILD-1:0] child_mask_t;

  // COLLECT gathers arrivals, WAIT_PARENT holds a forwarded barrier.
  typedef enum logic [1:0] {
    COLLECT     = 2'd0,
    WAIT_PARENT = 2'd1
  } node_state_e;

endpackage : fsync_node_pkg

`default_nettype wire

// File: hw/rtl/fractal_sync_4x4.sv
// fractal sync 4x4: two-level barrier tree, four quadrant leaves under one root.
`include "fractal_sync_defs.svh"
`default_nettype none

module fractal_sync_4x4 (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               req_i      [`FSYNC_N_CU],
  input  fsync_cu_pkg::lvl_t lvl_i      [`FSYNC_N_CU],
  output logic               wake_o     [`FSYNC_N_CU],
  output fsync_cu_pkg::lvl_t wake_lvl_o [`FSYNC_N_CU],
  output logic               error_o    [`FSYNC_N_CU]
);

  localparam int unsigned QUAD_DIM  = `FSYNC_GRID_DIM / 2;  // cus per quadrant side.
  localparam int unsigned QUAD_COLS = `FSYNC_GRID_DIM / QUAD_DIM;

  fsync_link_if leaf_link [`FSYNC_N_LEAF] ();
  fsync_link_if root_up ();

  // nothing sits above the root.
  assign root_up.wake     = 1'b0;
  assign root_up.wake_lvl = '0;
  assign root_up.error    = 1'b0;

  for (genvar l = 0; l < `FSYNC_N_LEAF; l++) begin : gen_leaf
    fsync_link_if cu_link [`FSYNC_N_CHILD] ();

    // slot s of leaf l back to its row-major cu index.
    for (genvar s = 0; s < `FSYNC_N_CHILD; s++) begin : gen_cu
      localparam int unsigned ROW = (l / QUAD_COLS) * QUAD_DIM + s / QUAD_DIM;
      localparam int unsigned COL = (l % QUAD_COLS) * QUAD_DIM + s % QUAD_DIM;
      localparam int unsigned CU  = ROW * `FSYNC_GRID_DIM + COL;

      assign cu_link[s].req     = req_i[CU];
      assign cu_link[s].req_lvl = lvl_i[CU];
      assign wake_o[CU]         = cu_link[s].wake;
      assign wake_lvl_o[CU]     = cu_link[s].wake_lvl;
      assign error_o[CU]        = cu_link[s].error;
    end

    fsync_node #(
      .NODE_LEVEL ( 1 )
    ) i_leaf (
      .clk_i    ( clk_i        ),
      .arst_n_i ( arst_n_i     ),
      .children ( cu_link      ),
      .up       ( leaf_link[l] )
    );
  end

  fsync_node #(
    .NODE_LEVEL ( `FSYNC_TOP_LVL )
  ) i_root (
    .clk_i    ( clk_i     ),
    .arst_n_i ( arst_n_i  ),
    .children ( leaf_link ),
    .up       ( root_up   )
  );

endmodule : fractal_sync_4x4

`default_nettype wire

// File: hw/rtl/fsync_arrival_tracker.sv
// fsync arrival tracker: arrival mask and level of the open barrier, with request checks.
`include "fractal_sync_defs.svh"
`default_nettype none

module fsync_arrival_tracker #(
  parameter int unsigned NODE_LEVEL = 1
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  fsync_node_pkg::child_mask_t req_i,
  input  fsync_cu_pkg::lvl_t          req_lvl_i [`FSYNC_N_CHILD],
  input  logic                        clear_i,
  output logic                        all_arrived_o,
  output fsync_cu_pkg::lvl_t          barrier_lvl_o,
  output fsync_node_pkg::child_mask_t err_o,
  output fsync_cu_pkg::lvl_t          err_lvl_o [`FSYNC_N_CHILD]
);

  localparam fsync_cu_pkg::lvl_t MIN_LVL = fsync_cu_pkg::lvl_t'(NODE_LEVEL);
  localparam fsync_cu_pkg::lvl_t MAX_LVL = fsync_cu_pkg::lvl_t'(`FSYNC_TOP_LVL);

  fsync_node_pkg::child_mask_t arrived_q;
  fsync_node_pkg::child_mask_t arrived_next;
  fsync_node_pkg::child_mask_t in_range;
  fsync_node_pkg::child_mask_t accept;
  fsync_node_pkg::child_mask_t err_q;
  fsync_cu_pkg::lvl_t          open_lvl_q;
  fsync_cu_pkg::lvl_t          err_lvl_q [`FSYNC_N_CHILD];
  logic                        open;

  assign open = |arrived_q;  // a barrier is open once anyone arrived.

  // levels this node may ever handle.
  always_comb begin
    for (int i = 0; i < `FSYNC_N_CHILD; i++) begin
      in_range[i] = req_i[i] && (req_lvl_i[i] >= MIN_LVL) && (req_lvl_i[i] <= MAX_LVL);
    end
  end

  // an empty tracker takes the level of the lowest valid requester.
  always_comb begin
    barrier_lvl_o = open_lvl_q;
    if (!open) begin
      for (int i = `FSYNC_N_CHILD - 1; i >= 0; i--) begin
        if (in_range[i]) begin
          barrier_lvl_o = req_lvl_i[i];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `FSYNC_N_CHILD; i++) begin
      accept[i] = in_range[i] && (req_lvl_i[i] == barrier_lvl_o) && !arrived_q[i];
    end
  end

  assign arrived_next  = arrived_q | accept;
  assign all_arrived_o = &arrived_next;  // includes this cycle's arrivals.

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      arrived_q  <= '0;
      open_lvl_q <= '0;
      err_q      <= '0;
    end else begin
      arrived_q <= clear_i ? '0 : arrived_next;
      if (!open && |accept) begin
        open_lvl_q <= barrier_lvl_o;
      end
      err_q <= req_i & ~accept;  // anything not accepted is bounced.
    end
  end

  // level of the bounced request, echoed with the error.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `FSYNC_N_CHILD; i++) begin
      if (req_i[i] && !accept[i]) begin
        err_lvl_q[i] <= req_lvl_i[i];
      end
    end
  end

  assign err_o     = err_q;
  assign err_lvl_o = err_lvl_q;

endmodule : fsync_arrival_tracker

`default_nettype wire

// File: hw/rtl/fsync_link_if.sv
// fsync link: one parent-child barrier link, request strobe up and wake/error down.
`default_nettype none

interface fsync_link_if;

  logic               req;       // one-cycle arrival strobe.
  fsync_cu_pkg::lvl_t req_lvl;
  logic               wake;      // one-cycle barrier release.
  fsync_cu_pkg::lvl_t wake_lvl;  // level of the wake or of the rejected request.
  logic               error;

  modport child (
    output req,
    output req_lvl,
    input  wake,
    input  wake_lvl,
    input  error
  );

  modport parent (
    input  req,
    input  req_lvl,
    output wake,
    output wake_lvl,
    output error
  );

endinterface : fsync_link_if

`default_nettype wire

// File: hw/rtl/fsync_node.sv
// fsync node: completes a barrier at its own level or forwards it up, then broadcasts the wake.
`include "fractal_sync_defs.svh"
`default_nettype none

module fsync_node #(
  parameter int unsigned NODE_LEVEL = 1
) (
  input  logic         clk_i,
  input  logic         arst_n_i,
  fsync_link_if.parent children [`FSYNC_N_CHILD],
  fsync_link_if.child  up
);

  localparam fsync_cu_pkg::lvl_t LOCAL_LVL = fsync_cu_pkg::lvl_t'(NODE_LEVEL);
  localparam bit                 HAS_UP    = (NODE_LEVEL < `FSYNC_TOP_LVL);

  fsync_node_pkg::child_mask_t req;
  fsync_cu_pkg::lvl_t          req_lvl [`FSYNC_N_CHILD];
  fsync_node_pkg::child_mask_t err;
  fsync_cu_pkg::lvl_t          err_lvl [`FSYNC_N_CHILD];
  logic                        all_arrived;
  fsync_cu_pkg::lvl_t          barrier_lvl;
  logic                        clear;
  logic                        fire;
  logic                        complete_local;
  logic                        forward;
  logic                        resume;
  logic                        parent_wake;
  fsync_cu_pkg::lvl_t          parent_wake_lvl;
  fsync_node_pkg::node_state_e state_q;
  logic                        wake_q;
  fsync_cu_pkg::lvl_t          wake_lvl_q;

  fsync_arrival_tracker #(
    .NODE_LEVEL ( NODE_LEVEL )
  ) i_tracker (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .req_i         ( req         ),
    .req_lvl_i     ( req_lvl     ),
    .clear_i       ( clear       ),
    .all_arrived_o ( all_arrived ),
    .barrier_lvl_o ( barrier_lvl ),
    .err_o         ( err         ),
    .err_lvl_o     ( err_lvl     )
  );

  assign fire           = (state_q == fsync_node_pkg::COLLECT) && all_arrived;
  assign complete_local = fire && (barrier_lvl == LOCAL_LVL);
  assign forward        = HAS_UP && fire && !complete_local;  // barrier spans more than us.
  assign resume         = (state_q == fsync_node_pkg::WAIT_PARENT) && parent_wake;
  assign clear          = complete_local || resume;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= fsync_node_pkg::COLLECT;
      wake_q  <= 1'b0;
    end else begin
      wake_q <= clear;
      if (forward) begin
        state_q <= fsync_node_pkg::WAIT_PARENT;
      end else if (resume) begin
        state_q <= fsync_node_pkg::COLLECT;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (complete_local) begin
      wake_lvl_q <= barrier_lvl;
    end else if (resume) begin
      wake_lvl_q <= parent_wake_lvl;  // echo what the parent released.
    end
  end

  // upward request path, only below the top level.
  if (HAS_UP) begin : gen_up
    logic               up_req_q;
    fsync_cu_pkg::lvl_t up_req_lvl_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        up_req_q <= 1'b0;
      end else begin
        up_req_q <= forward;
      end
    end

    always_ff @(posedge clk_i) begin
      if (forward) begin
        up_req_lvl_q <= barrier_lvl;
      end
    end

    assign up.req          = up_req_q;
    assign up.req_lvl      = up_req_lvl_q;
    assign parent_wake     = up.wake;
    assign parent_wake_lvl = up.wake_lvl;
  end else begin : gen_no_up
    assign up.req          = 1'b0;  // root link stays idle.
    assign up.req_lvl      = '0;
    assign parent_wake     = 1'b0;
    assign parent_wake_lvl = '0;
  end

  for (genvar i = 0; i < `FSYNC_N_CHILD; i++) begin : gen_child
    assign req[i]               = children[i].req;
    assign req_lvl[i]           = children[i].req_lvl;
    assign children[i].wake     = wake_q;
    assign children[i].wake_lvl = wake_q ? wake_lvl_q : err_lvl[i];
    assign children[i].error    = err[i];
  end

endmodule : fsync_node

`default_nettype wire

// File: verification/fsync_model.svh
// fsync model: barrier completion per quadrant and for the array, with typed compares.
`ifndef FSYNC_MODEL_SVH
`define FSYNC_MODEL_SVH

fsync_cu_pkg::lvl_t q_lvl [4];   // open level per quadrant.
logic [3:0]         q_arr [4];   // arrived cus, indexed by slot.
logic [3:0]         root_arr;    // quadrants forwarded to the root.
logic [15:0]        exp_wake [4];  // ring of expected pulses by cycle.
logic [15:0]        exp_err [4];
fsync_cu_pkg::lvl_t exp_lvl [4][16];

// row-major cu index to quadrant and slot.
function automatic int quad_of(int cu);
  return ((cu / 4) / 2) * 2 + (cu % 4) / 2;
endfunction

function automatic int slot_of(int cu);
  return ((cu / 4) % 2) * 2 + (cu % 4) % 2;
endfunction

function automatic int quad_cu(int q, int s);
  return ((q / 2) * 2 + s / 2) * 4 + (q % 2) * 2 + s % 2;
endfunction

function automatic logic [15:0] quad_mask(int q);
  logic [15:0] m;
  m = '0;
  for (int s = 0; s < 4; s++) begin
    m[quad_cu(q, s)] = 1'b1;
  end
  return m;
endfunction

task automatic expect_pulse(int cu, int delay, bit is_err, fsync_cu_pkg::lvl_t l);
  int slot;
  slot = (cyc + delay) % 4;
  if (is_err) begin
    exp_err[slot][cu] = 1'b1;
  end else begin
    exp_wake[slot][cu] = 1'b1;
  end
  exp_lvl[slot][cu] = l;
endtask

task automatic model_request(int cu, fsync_cu_pkg::lvl_t l);
  int  q;
  int  s;
  bit  bad;
  q   = quad_of(cu);
  s   = slot_of(cu);
  bad = (l < 1) || (l > `FSYNC_TOP_LVL) || q_arr[q][s];
  bad = bad || ((q_arr[q] != 0) && (l != q_lvl[q]));  // other level already open.
  if (bad) begin
    expect_pulse(cu, 1, 1'b1, l);
  end else begin
    if (q_arr[q] == 0) begin
      q_lvl[q] = l;
    end
    q_arr[q][s] = 1'b1;
    if (&q_arr[q] && l == 1) begin
      for (int i = 0; i < 4; i++) begin
        expect_pulse(quad_cu(q, i), 1, 1'b0, l);
      end
      q_arr[q] = '0;
    end else if (&q_arr[q]) begin
      root_arr[q] = 1'b1;
      if (&root_arr) begin  // leaf, root and leaf again.
        for (int i = 0; i < 16; i++) begin
          expect_pulse(i, 3, 1'b0, l);
        end
        for (int i = 0; i < 4; i++) begin
          q_arr[i] = '0;
        end
        root_arr = '0;
      end
    end
  end
endtask

task automatic check_wake(string sig, int idx, logic got, logic want);
  if (got !== want) begin
    $display("mismatch at %0t: %s[%0d] got %b expected %b", $time, sig, idx, got, want);
    abort_run();
  end
endtask

task automatic check_lvl(string sig, int idx, fsync_cu_pkg::lvl_t got,
                         fsync_cu_pkg::lvl_t want);
  if (got !== want) begin
    $display("mismatch at %0t: %s[%0d] got %0d expected %0d", $time, sig, idx, got, want);
    abort_run();
  end
endtask

task automatic check_error(string sig, int idx, logic got, logic want);
  if (got !== want) begin
    $display("mismatch at %0t: %s[%0d] got %b expected %b", $time, sig, idx, got, want);
    abort_run();
  end
endtask

`endif

// File: verification/tb_fractal_sync_4x4.sv
// fractal sync testbench driving random barrier traffic on the 4x4 array against a cycle model.
`include "fractal_sync_defs.svh"
`default_nettype none

module tb_fractal_sync_4x4;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 8;  // cycles allowed for an expected pulse.

  logic                  clk;
  logic                  arst_n;
  logic                  req [`FSYNC_N_CU];
  fsync_cu_pkg::lvl_t    lvl [`FSYNC_N_CU];
  logic                  wake [`FSYNC_N_CU];
  fsync_cu_pkg::lvl_t    wake_lvl [`FSYNC_N_CU];
  logic                  error [`FSYNC_N_CU];
  integer                seed;
  int                    cyc;
  logic [15:0]           seen_wake;  // pulses observed since last cleared.
  logic [15:0]           seen_err;
  fsync_cu_pkg::cu_idx_t order [16];

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "testbench stopped at the first error");
  endtask

  `include "fsync_model.svh"

  fractal_sync_4x4 dut (
    .clk_i      ( clk      ),
    .arst_n_i   ( arst_n   ),
    .req_i      ( req      ),
    .lvl_i      ( lvl      ),
    .wake_o     ( wake     ),
    .wake_lvl_o ( wake_lvl ),
    .error_o    ( error    )
  );

  always #50 clk = ~clk;

  // compare what the last edge produced and drop the strobes.
  task automatic step();
    int slot;
    @(posedge clk);
    #10;
    cyc++;
    slot = cyc % 4;
    for (int i = 0; i < 16; i++) begin
      check_wake("wake_o", i, wake[i], exp_wake[slot][i]);
      check_error("error_o", i, error[i], exp_err[slot][i]);
      if (exp_wake[slot][i] || exp_err[slot][i]) begin
        check_lvl("wake_lvl_o", i, wake_lvl[i], exp_lvl[slot][i]);
      end
      seen_wake[i] = seen_wake[i] | (wake[i] === 1'b1);
      seen_err[i]  = seen_err[i] | (error[i] === 1'b1);
      req[i] = 1'b0;
    end
    exp_wake[slot] = '0;
    exp_err[slot]  = '0;
  endtask

  task automatic request(int cu, fsync_cu_pkg::lvl_t l);
    req[cu] = 1'b1;
    lvl[cu] = l;
    model_request(cu, l);
  endtask

  task automatic wait_pulses(logic [15:0] mask, bit for_error);
    int n;
    n = 0;
    while ((((for_error ? seen_err : seen_wake) & mask) != mask) && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (((for_error ? seen_err : seen_wake) & mask) != mask) begin
      $display("timeout: no %s pulse on cu mask %h after %0d cycles",
               for_error ? "error" : "wake", mask, WAIT_LIMIT);
      abort_run();
    end
  endtask

  // fisher-yates over the first n entries of order.
  task automatic shuffle(int n);
    int                    j;
    fsync_cu_pkg::cu_idx_t t;
    for (int i = n - 1; i > 0; i--) begin
      j = $unsigned($random(seed)) % (i + 1);
      t = order[i];
      order[i] = order[j];
      order[j] = t;
    end
  endtask

  task automatic quad_barrier();
    int q;
    q = $unsigned($random(seed)) % 4;
    for (int i = 0; i < 4; i++) begin
      order[i] = fsync_cu_pkg::cu_idx_t'(quad_cu(q, i));
    end
    shuffle(4);
    seen_wake = '0;
    for (int i = 0; i < 4; i++) begin
      request(order[i], 2'd1);
      step();
      if ($random(seed) & 1) begin
        step();  // idle gap.
      end
    end
    wait_pulses(quad_mask(q), 1'b0);
  endtask

  task automatic array_barrier();
    for (int i = 0; i < 16; i++) begin
      order[i] = fsync_cu_pkg::cu_idx_t'(i);
    end
    shuffle(16);
    seen_wake = '0;
    for (int i = 0; i < 16; i++) begin
      request(order[i], 2'd2);
      step();
      if ($random(seed) & 1) begin
        step();
      end
    end
    wait_pulses(16'hffff, 1'b0);
  endtask

  // bad level, level mismatch and repeat inside an open quadrant barrier.
  task automatic faulty_barrier();
    int                 q;
    fsync_cu_pkg::lvl_t bad;
    q = $unsigned($random(seed)) % 4;
    for (int i = 0; i < 4; i++) begin
      order[i] = fsync_cu_pkg::cu_idx_t'(quad_cu(q, i));
    end
    shuffle(4);
    bad = ($random(seed) & 1) ? 2'd3 : 2'd0;
    seen_wake = '0;
    seen_err  = '0;
    request(order[0], 2'd1);
    step();
    request(order[1], 2'd1);
    request(order[2], bad);
    step();
    wait_pulses(16'd1 << order[2], 1'b1);
    request(order[3], 2'd2);
    request(order[0], 2'd1);
    step();
    wait_pulses((16'd1 << order[3]) | (16'd1 << order[0]), 1'b1);
    request(order[2], 2'd1);
    request(order[3], 2'd1);
    step();
    wait_pulses(quad_mask(q), 1'b0);
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    seed      = 32'hf6e7;
    cyc       = 0;
    seen_wake = '0;
    seen_err  = '0;
    root_arr  = '0;
    for (int i = 0; i < 16; i++) begin
      req[i] = 1'b0;
      lvl[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      q_arr[i]    = '0;
      q_lvl[i]    = '0;
      exp_wake[i] = '0;
      exp_err[i]  = '0;
    end
    repeat (16) @(posedge clk);
    #10;
    arst_n = 1'b1;
    repeat (20) step();  // quiet after reset.
    repeat (8) quad_barrier();
    repeat (3) array_barrier();
    repeat (4) faulty_barrier();
    quad_barrier();
    array_barrier();
    repeat (4) step();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule : tb_fractal_sync_4x4

`default_nettype wire

// File: vlog.f
+incdir+hw/include
+incdir+verification
hw/pkg/fsync_cu_pkg.sv
hw/pkg/fsync_node_pkg.sv
hw/rtl/fsync_link_if.sv
hw/rtl/fsync_arrival_tracker.sv
hw/rtl/fsync_node.sv
hw/rtl/fractal_sync_4x4.sv
verification/tb_fractal_sync_4x4.sv
